//--- src/vec_ctrl_pkg.sv
// Shared widths, field codes, CSR selectors and the instruction word layout, imported by all blocks
package vec_ctrl_pkg;

  // Scalar operand and result width
  localparam int unsigned XLEN = 32;

  // Instruction classes in the top three bits of the word
  localparam logic [2:0] CLS_CFG = 3'd0;
  localparam logic [2:0] CLS_CSR = 3'd1;
  localparam logic [2:0] CLS_VFU = 3'd2;
  localparam logic [2:0] CLS_LSU = 3'd3;

  // Element width codes, 3 and above are illegal
  localparam logic [2:0] SEW_8  = 3'd0;
  localparam logic [2:0] SEW_16 = 3'd1;
  localparam logic [2:0] SEW_32 = 3'd2;

  // Register group codes, 4 and 5 reserved
  localparam logic [2:0] LMUL_1  = 3'd0;
  localparam logic [2:0] LMUL_2  = 3'd1;
  localparam logic [2:0] LMUL_4  = 3'd2;
  localparam logic [2:0] LMUL_8  = 3'd3;
  localparam logic [2:0] LMUL_F4 = 3'd6;
  localparam logic [2:0] LMUL_F2 = 3'd7;

  // CSR read selectors
  localparam logic [1:0] CSR_SEL_VL    = 2'd0;
  localparam logic [1:0] CSR_SEL_VTYPE = 2'd1;
  localparam logic [1:0] CSR_SEL_VLENB = 2'd2;

  // One instruction word, seen as a configuration or as an operation
  typedef union packed {
    struct packed {
      logic [2:0]  cls;
      logic [4:0]  rd;
      logic        keep_vl;
      logic [2:0]  vsew;
      logic [2:0]  vlmul;
      logic [16:0] zero;
    } cfg;
    struct packed {
      logic [2:0] cls;
      logic [4:0] rd;
      logic [4:0] vd;
      logic [4:0] vs1;
      logic [4:0] vs2;
      logic [1:0] csr_sel;
      logic [6:0] zero;
    } op;
  } vec_instr_u;

endpackage

//--- src/vec_req_if.sv
// Valid/ready request channel, instantiated in the top level between decoder, buffer and issuer
`timescale 1ns/1ps

interface vec_req_if;
  import vec_ctrl_pkg::*;

  logic            valid;
  logic            ready;
  vec_instr_u      instr;
  logic [XLEN-1:0] rs1;

  // Sending side
  modport write (
    output valid,
    output instr,
    output rs1,
    input  ready
  );

  // Receiving side
  modport read (
    input  valid,
    input  instr,
    input  rs1,
    output ready
  );

endinterface

//--- src/vec_decoder.sv
// Host-facing decoder that accepts or rejects instruction words and registers accepted ones
`timescale 1ns/1ps

module vec_decoder (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Host issue
  input  logic                          issue_valid_i,
  output logic                          issue_ready_o,
  input  vec_ctrl_pkg::vec_instr_u      issue_instr_i,
  input  logic [vec_ctrl_pkg::XLEN-1:0] issue_rs1_i,
  output logic                          issue_accept_o,
  // Current vtype state
  input  logic                          vill_i,
  // To request buffer
  vec_req_if.write                      req_o
);
  import vec_ctrl_pkg::*;

  logic            valid_q;
  vec_instr_u      instr_q;
  logic [XLEN-1:0] rs1_q;
  logic            is_vector;
  logic            handshake;

  assign is_vector = (issue_instr_i.op.cls == CLS_VFU) || (issue_instr_i.op.cls == CLS_LSU);

  // Legal class, and no vector work under an illegal vtype
  assign issue_accept_o = (issue_instr_i.op.cls <= CLS_LSU) && !(is_vector && vill_i);

  // Free slot, or the held word leaves this cycle
  assign issue_ready_o = !valid_q || req_o.ready;
  assign handshake     = issue_valid_i && issue_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (handshake) begin
      // Rejected words leave the slot empty
      valid_q <= issue_accept_o;
    end else if (req_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (handshake && issue_accept_o) begin
      instr_q <= issue_instr_i;
      rs1_q   <= issue_rs1_i;
    end
  end

  assign req_o.valid = valid_q;
  assign req_o.instr = instr_q;
  assign req_o.rs1   = rs1_q;

endmodule

//--- src/vec_req_buffer.sv
// One-entry fall-through buffer placed between the decoder and the issuer
`timescale 1ns/1ps

module vec_req_buffer (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // From decoder
  vec_req_if.read  req_i,
  // To issuer
  vec_req_if.write req_o
);
  import vec_ctrl_pkg::*;

  logic            full_q;
  vec_instr_u      instr_q;
  logic [XLEN-1:0] rs1_q;
  logic            store;

  // Stored word has priority over the incoming one
  assign req_i.ready = !full_q;
  assign req_o.valid = full_q || req_i.valid;
  assign req_o.instr = full_q ? instr_q : req_i.instr;
  assign req_o.rs1   = full_q ? rs1_q : req_i.rs1;

  // Incoming word that cannot pass straight through
  assign store = req_i.valid && !full_q && !req_o.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (store) begin
      full_q <= 1'b1;
    end else if (full_q && req_o.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      instr_q <= req_i.instr;
      rs1_q   <= req_i.rs1;
    end
  end

endmodule

//--- src/vec_csr_file.sv
// Holds vl and vtype, computes the vl of a configuration word and muxes CSR read data
`timescale 1ns/1ps

module vec_csr_file #(
  parameter int unsigned VLEN = 256
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Configuration commit
  input  logic                          cfg_valid_i,
  input  vec_ctrl_pkg::vec_instr_u      cfg_instr_i,
  input  logic [vec_ctrl_pkg::XLEN-1:0] cfg_rs1_i,
  output logic [vec_ctrl_pkg::XLEN-1:0] new_vl_o,
  // CSR read
  input  logic [1:0]                    csr_sel_i,
  output logic [vec_ctrl_pkg::XLEN-1:0] csr_data_o,
  // Current state
  output logic [vec_ctrl_pkg::XLEN-1:0] vl_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] vtype_o,
  output logic                          vill_o
);
  import vec_ctrl_pkg::*;

  localparam logic [XLEN-1:0] VLENB = XLEN'(VLEN / 8);

  logic [XLEN-1:0] vl_q;
  logic            vill_q;
  logic [2:0]      vsew_q;
  logic [2:0]      vlmul_q;
  logic            vill_d;
  logic [2:0]      vsew_d;
  logic [2:0]      vlmul_d;
  logic [XLEN-1:0] vlmax;
  logic            illegal;

  // SEW exponent minus LMUL exponent, fractional groups count negative
  function automatic logic signed [4:0] vtype_ratio(input logic [2:0] sew,
                                                    input logic [2:0] lmul);
    logic signed [4:0] lmul_log2;
    case (lmul)
      LMUL_F4: lmul_log2 = -5'sd2;
      LMUL_F2: lmul_log2 = -5'sd1;
      default: lmul_log2 = $signed({2'b00, lmul});
    endcase
    return $signed({2'b00, sew}) - lmul_log2;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    vsew_d  = cfg_instr_i.cfg.vsew;
    vlmul_d = cfg_instr_i.cfg.vlmul;
    vill_d  = 1'b0;

    illegal = (vsew_d > SEW_32) ||
              !(vlmul_d inside {LMUL_1, LMUL_2, LMUL_4, LMUL_8, LMUL_F4, LMUL_F2}) ||
              ((vlmul_d == LMUL_F4) && (vsew_d != SEW_8)) ||
              ((vlmul_d == LMUL_F2) && (vsew_d == SEW_32));

    // Elements per register, then scaled by the group size
    vlmax = VLENB >> vsew_d;
    case (vlmul_d)
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_F2: vlmax = vlmax >> 1;
      default: vlmax = vlmax;
    endcase

    if (!cfg_instr_i.cfg.keep_vl) begin
      if (cfg_rs1_i == '1) begin
        new_vl_o = vlmax;
      end else begin
        new_vl_o = (cfg_rs1_i < vlmax) ? cfg_rs1_i : vlmax;
      end
    end else begin
      new_vl_o = vl_q;
      // Keeping vl is only allowed at the same SEW/LMUL ratio
      if (vtype_ratio(vsew_d, vlmul_d) != vtype_ratio(vsew_q, vlmul_q)) begin
        illegal = 1'b1;
      end
    end

    if (illegal) begin
      vill_d   = 1'b1;
      vsew_d   = SEW_8;
      vlmul_d  = LMUL_1;
      new_vl_o = '0;
    end
  end

  // Reset state is an illegal vtype with vl = 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vl_q    <= '0;
      vill_q  <= 1'b1;
      vsew_q  <= SEW_8;
      vlmul_q <= LMUL_1;
    end else if (cfg_valid_i) begin
      vl_q    <= new_vl_o;
      vill_q  <= vill_d;
      vsew_q  <= vsew_d;
      vlmul_q <= vlmul_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  // vill at the top, vsew and vlmul in the low six bits
  assign vtype_o = {vill_q, {(XLEN - 7){1'b0}}, vsew_q, vlmul_q};
  assign vl_o    = vl_q;
  assign vill_o  = vill_q;

  always_comb begin
    case (csr_sel_i)
      CSR_SEL_VL:    csr_data_o = vl_q;
      CSR_SEL_VTYPE: csr_data_o = vtype_o;
      CSR_SEL_VLENB: csr_data_o = VLENB;
      default:       csr_data_o = '0;
    endcase
  end

endmodule

//--- src/vec_insn_tracker.sv
// Busy bit per instruction id, used by the issuer to hand out the lowest free id
`timescale 1ns/1ps

module vec_insn_tracker #(
  parameter  int unsigned NR_INSN = 4,
  localparam int unsigned ID_W    = $clog2(NR_INSN)
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // Allocation
  input  logic            alloc_i,
  output logic [ID_W-1:0] free_id_o,
  output logic            full_o,
  // Completions
  input  logic            vfu_done_valid_i,
  input  logic [ID_W-1:0] vfu_done_id_i,
  input  logic            lsu_done_valid_i,
  input  logic [ID_W-1:0] lsu_done_id_i
);

  logic [NR_INSN-1:0] busy_q;
  logic [NR_INSN-1:0] busy_d;

  // Scan downwards so the lowest free id wins
  always_comb begin
    free_id_o = '0;
    for (int i = NR_INSN - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_id_o = ID_W'(i);
      end
    end
  end

  assign full_o = &busy_q;

  always_comb begin
    busy_d = busy_q;
    if (alloc_i) begin
      busy_d[free_id_o] = 1'b1;
    end
    if (vfu_done_valid_i) begin
      busy_d[vfu_done_id_i] = 1'b0;
    end
    if (lsu_done_valid_i) begin
      busy_d[lsu_done_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

endmodule

//--- src/vec_issuer.sv
// Consumes buffered requests, retiring config and CSR words to the host and sending vector work
`timescale 1ns/1ps

module vec_issuer #(
  parameter  int unsigned VLEN    = 256,
  parameter  int unsigned NR_INSN = 4,
  localparam int unsigned ID_W    = $clog2(NR_INSN)
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // From request buffer
  vec_req_if.read                       req_i,
  output logic                          vill_o,
  // Host result
  output logic                          result_valid_o,
  input  logic                          result_ready_i,
  output logic [4:0]                    result_rd_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] result_data_o,
  // Unit requests
  output logic                          vfu_req_valid_o,
  input  logic                          vfu_req_ready_i,
  output logic                          lsu_req_valid_o,
  input  logic                          lsu_req_ready_i,
  output logic [ID_W-1:0]               req_id_o,
  output vec_ctrl_pkg::vec_instr_u      req_instr_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_rs1_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_vl_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_vtype_o,
  // Completions
  input  logic                          vfu_done_valid_i,
  input  logic [ID_W-1:0]               vfu_done_id_i,
  input  logic                          lsu_done_valid_i,
  input  logic [ID_W-1:0]               lsu_done_id_i
);
  import vec_ctrl_pkg::*;

  logic            is_cfg;
  logic            is_csr;
  logic            is_vfu;
  logic            is_lsu;
  logic            cfg_commit;
  logic            alloc;
  logic            full;
  logic [XLEN-1:0] new_vl;
  logic [XLEN-1:0] csr_data;

  assign is_cfg = req_i.instr.op.cls == CLS_CFG;
  assign is_csr = req_i.instr.op.cls == CLS_CSR;
  assign is_vfu = req_i.instr.op.cls == CLS_VFU;
  assign is_lsu = req_i.instr.op.cls == CLS_LSU;

  // Host result for config and CSR words
  assign result_valid_o = req_i.valid && (is_cfg || is_csr);
  assign result_rd_o    = req_i.instr.op.rd;
  assign result_data_o  = is_cfg ? new_vl : csr_data;
  assign cfg_commit     = req_i.valid && is_cfg && result_ready_i;

  // Vector work waits for a free id
  assign vfu_req_valid_o = req_i.valid && is_vfu && !full;
  assign lsu_req_valid_o = req_i.valid && is_lsu && !full;
  assign alloc = (vfu_req_valid_o && vfu_req_ready_i) || (lsu_req_valid_o && lsu_req_ready_i);

  assign req_i.ready = ((is_cfg || is_csr) && result_ready_i) ||
                       (is_vfu && !full && vfu_req_ready_i) ||
                       (is_lsu && !full && lsu_req_ready_i);

  assign req_instr_o = req_i.instr;
  assign req_rs1_o   = req_i.rs1;

  vec_csr_file #(
    .VLEN (VLEN)
  ) csr_file_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_valid_i (cfg_commit),
    .cfg_instr_i (req_i.instr),
    .cfg_rs1_i   (req_i.rs1),
    .new_vl_o    (new_vl),
    .csr_sel_i   (req_i.instr.op.csr_sel),
    .csr_data_o  (csr_data),
    .vl_o        (req_vl_o),
    .vtype_o     (req_vtype_o),
    .vill_o      (vill_o)
  );

  vec_insn_tracker #(
    .NR_INSN (NR_INSN)
  ) insn_tracker_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .alloc_i          (alloc),
    .free_id_o        (req_id_o),
    .full_o           (full),
    .vfu_done_valid_i (vfu_done_valid_i),
    .vfu_done_id_i    (vfu_done_id_i),
    .lsu_done_valid_i (lsu_done_valid_i),
    .lsu_done_id_i    (lsu_done_id_i)
  );

endmodule

//--- src/vec_ctrl_top.sv
// Top level of the vector issue controller, connecting host and units through plain ports
`timescale 1ns/1ps

module vec_ctrl_top #(
  parameter  int unsigned VLEN    = 256,
  parameter  int unsigned NR_INSN = 4,
  localparam int unsigned ID_W    = $clog2(NR_INSN)
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Host issue
  input  logic                          issue_valid_i,
  output logic                          issue_ready_o,
  input  vec_ctrl_pkg::vec_instr_u      issue_instr_i,
  input  logic [vec_ctrl_pkg::XLEN-1:0] issue_rs1_i,
  output logic                          issue_accept_o,
  // Host result
  output logic                          result_valid_o,
  input  logic                          result_ready_i,
  output logic [4:0]                    result_rd_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] result_data_o,
  // Unit requests
  output logic                          vfu_req_valid_o,
  input  logic                          vfu_req_ready_i,
  output logic                          lsu_req_valid_o,
  input  logic                          lsu_req_ready_i,
  output logic [ID_W-1:0]               req_id_o,
  output vec_ctrl_pkg::vec_instr_u      req_instr_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_rs1_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_vl_o,
  output logic [vec_ctrl_pkg::XLEN-1:0] req_vtype_o,
  // Completions
  input  logic                          vfu_done_valid_i,
  input  logic [ID_W-1:0]               vfu_done_id_i,
  input  logic                          lsu_done_valid_i,
  input  logic [ID_W-1:0]               lsu_done_id_i
);

  // Decoder to buffer, buffer to issuer
  vec_req_if dec_req ();
  vec_req_if buf_req ();

  logic vill;

  vec_decoder decoder_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_ready_o  (issue_ready_o),
    .issue_instr_i  (issue_instr_i),
    .issue_rs1_i    (issue_rs1_i),
    .issue_accept_o (issue_accept_o),
    .vill_i         (vill),
    .req_o          (dec_req)
  );

  vec_req_buffer req_buffer_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (dec_req),
    .req_o    (buf_req)
  );

  vec_issuer #(
    .VLEN    (VLEN),
    .NR_INSN (NR_INSN)
  ) issuer_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (buf_req),
    .vill_o           (vill),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i),
    .result_rd_o      (result_rd_o),
    .result_data_o    (result_data_o),
    .vfu_req_valid_o  (vfu_req_valid_o),
    .vfu_req_ready_i  (vfu_req_ready_i),
    .lsu_req_valid_o  (lsu_req_valid_o),
    .lsu_req_ready_i  (lsu_req_ready_i),
    .req_id_o         (req_id_o),
    .req_instr_o      (req_instr_o),
    .req_rs1_o        (req_rs1_o),
    .req_vl_o         (req_vl_o),
    .req_vtype_o      (req_vtype_o),
    .vfu_done_valid_i (vfu_done_valid_i),
    .vfu_done_id_i    (vfu_done_id_i),
    .lsu_done_valid_i (lsu_done_valid_i),
    .lsu_done_id_i    (lsu_done_id_i)
  );

endmodule

//--- verification/vec_ctrl_checks.svh
// Reference model, dispatch checks and error counting, included inside the testbench module
`ifndef VEC_CTRL_CHECKS_SVH
`define VEC_CTRL_CHECKS_SVH

int    errors    = 0;
string test_name = "none";

// Compare one value against the reference model
task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
  assert (act == exp) else begin
    $display("** Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    errors++;
  end
endtask

task automatic flag_problem(input string msg);
  $display("%s: %s", test_name, msg);
  errors++;
endtask

////////////////////////////////////////////////////////////////////////////
// Reference model of the configuration rules
////////////////////////////////////////////////////////////////////////////

// Group size as num/den
function automatic int lmul_num(input logic [2:0] lmul);
  return (lmul <= LMUL_8) ? (1 << lmul) : 1;
endfunction

function automatic int lmul_den(input logic [2:0] lmul);
  return (lmul == LMUL_F4) ? 4 : ((lmul == LMUL_F2) ? 2 : 1);
endfunction

function automatic bit vtype_bad(input logic [2:0] sew, input logic [2:0] lmul);
  return (sew > SEW_32) || (lmul == 3'd4) || (lmul == 3'd5) ||
         ((lmul == LMUL_F4) && (sew != SEW_8)) || ((lmul == LMUL_F2) && (sew == SEW_32));
endfunction

// Element bits per group unit
// Equal values allow vl to be kept
function automatic int sew_per_lmul(input logic [2:0] sew, input logic [2:0] lmul);
  return ((8 << sew) * lmul_den(lmul)) / lmul_num(lmul);
endfunction

task automatic ref_cfg(input vec_instr_u w, input logic [31:0] rs1, input logic [31:0] old_vl,
                       input logic [31:0] old_vtype, output logic [31:0] vl,
                       output logic [31:0] vtype);
  int vlmax;
  bit bad;
  bad = vtype_bad(w.cfg.vsew, w.cfg.vlmul);
  if (w.cfg.keep_vl && !bad) begin
    bad = sew_per_lmul(w.cfg.vsew, w.cfg.vlmul) != sew_per_lmul(old_vtype[5:3], old_vtype[2:0]);
  end
  if (bad) begin
    vl    = 32'd0;
    vtype = 32'h8000_0000;
  end else begin
    vlmax = (VLEN / (8 << w.cfg.vsew)) * lmul_num(w.cfg.vlmul) / lmul_den(w.cfg.vlmul);
    if (w.cfg.keep_vl) begin
      vl = old_vl;
    end else begin
      vl = ((rs1 == '1) || (rs1 > vlmax)) ? vlmax : rs1;
    end
    vtype = {26'd0, w.cfg.vsew, w.cfg.vlmul};
  end
endtask

function automatic int lowest_free(input logic [NR_INSN-1:0] busy);
  for (int i = 0; i < NR_INSN; i++) begin
    if (!busy[i]) begin
      return i;
    end
  end
  return -1;
endfunction

// Unit request seen at a handshake edge
// Matched against the oldest accepted vector op
task automatic check_dispatch(input logic to_lsu);
  vec_instr_u  w;
  logic [31:0] rs1;
  if (busy_model[req_id_o]) begin
    flag_problem("an id still in flight was handed out again");
  end
  if (sent_instr.size() == 0) begin
    flag_problem("unit request without an accepted vector op");
  end else begin
    w   = sent_instr.pop_front();
    rs1 = sent_rs1.pop_front();
    check_value("request unit", w.op.cls == CLS_LSU, to_lsu);
    check_value("request instr", w, req_instr_o);
    check_value("request rs1", rs1, req_rs1_o);
  end
  check_value("request id", lowest_free(busy_model), req_id_o);
  check_value("request vl", exp_vl, req_vl_o);
  check_value("request vtype", exp_vtype, req_vtype_o);
endtask

held_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |=>
    result_valid_o && $stable(result_rd_o) && $stable(result_data_o))
  else flag_problem("held result changed before it was taken");

one_unit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(vfu_req_valid_o && lsu_req_valid_o))
  else flag_problem("both units requested in the same cycle");

no_req_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (&busy_model) |-> (!vfu_req_valid_o && !lsu_req_valid_o))
  else flag_problem("unit request while every id is busy");

`endif

//--- verification/vec_ctrl_tb.sv
// Testbench for the vector issue controller, models host and units and checks every response
`timescale 1ns/1ps

module vec_ctrl_tb;
  import vec_ctrl_pkg::*;

  localparam int VLEN    = 256;
  localparam int NR_INSN = 4;
  localparam int ID_W    = $clog2(NR_INSN);
  localparam int TIMEOUT = 200;

  logic              clk_i;
  logic              arst_n_i;
  logic              issue_valid_i;
  logic              issue_ready_o;
  vec_instr_u        issue_instr_i;
  logic [XLEN-1:0]   issue_rs1_i;
  logic              issue_accept_o;
  logic              result_valid_o;
  logic              result_ready_i;
  logic [4:0]        result_rd_o;
  logic [XLEN-1:0]   result_data_o;
  logic              vfu_req_valid_o;
  logic              vfu_req_ready_i;
  logic              lsu_req_valid_o;
  logic              lsu_req_ready_i;
  logic [ID_W-1:0]   req_id_o;
  vec_instr_u        req_instr_o;
  logic [XLEN-1:0]   req_rs1_o;
  logic [XLEN-1:0]   req_vl_o;
  logic [XLEN-1:0]   req_vtype_o;
  logic              vfu_done_valid_i;
  logic [ID_W-1:0]   vfu_done_id_i;
  logic              lsu_done_valid_i;
  logic [ID_W-1:0]   lsu_done_id_i;

  // Expected state and unit bookkeeping
  logic [31:0]        exp_vl;
  logic [31:0]        exp_vtype;
  logic [NR_INSN-1:0] busy_model;
  logic               lsu_of_id [NR_INSN];
  int                 pending[$];
  vec_instr_u         sent_instr[$];
  logic [31:0]        sent_rs1[$];
  int                 dispatched;
  logic [31:0]        rng_main;
  logic [31:0]        rng_ready;
  int                 tests_run;
  int                 tests_failed;
  int                 errors_at_start;

  `include "vec_ctrl_checks.svh"

  vec_ctrl_top vec_ctrl_top_inst (.*);

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Unit models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    rng_ready       = lcg(rng_ready);
    vfu_req_ready_i = rng_ready[31];
    lsu_req_ready_i = rng_ready[29];
  end

  always @(posedge clk_i) begin : unit_monitor
    if (arst_n_i && ((vfu_req_valid_o && vfu_req_ready_i) ||
                     (lsu_req_valid_o && lsu_req_ready_i))) begin
      check_dispatch(lsu_req_valid_o);
      busy_model[req_id_o] = 1'b1;
      lsu_of_id[req_id_o]  = lsu_req_valid_o;
      pending.push_back(req_id_o);
      dispatched++;
    end
    if (vfu_done_valid_i) begin
      busy_model[vfu_done_id_i] = 1'b0;
    end
    if (lsu_done_valid_i) begin
      busy_model[lsu_done_id_i] = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic issue_word(input vec_instr_u w, input logic [31:0] rs1, input logic exp_accept);
    int cnt;
    cnt           = 0;
    issue_valid_i = 1'b1;
    issue_instr_i = w;
    issue_rs1_i   = rs1;
    @(posedge clk_i);
    while (!issue_ready_o) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("issue port never became ready");
      end
      @(posedge clk_i);
    end
    check_value("issue accept", exp_accept, issue_accept_o);
    #1;
    issue_valid_i = 1'b0;
  endtask

  task automatic get_result(output logic [4:0] rd, output logic [31:0] data);
    int cnt;
    cnt            = 0;
    result_ready_i = 1'b1;
    @(posedge clk_i);
    while (!result_valid_o) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("no host result arrived");
      end
      @(posedge clk_i);
    end
    rd   = result_rd_o;
    data = result_data_o;
    #1;
    result_ready_i = 1'b0;
  endtask

  task automatic read_csr(input logic [1:0] sel, input logic [31:0] exp);
    vec_instr_u  w;
    logic [4:0]  rd;
    logic [31:0] data;
    w            = '0;
    w.op.cls     = CLS_CSR;
    w.op.rd      = 5'(sel + 3);
    w.op.csr_sel = sel;
    issue_word(w, 32'd0, 1'b1);
    get_result(rd, data);
    check_value("csr rd", w.op.rd, rd);
    check_value("csr data", exp, data);
  endtask

  // Config word, then read vl and vtype back
  task automatic configure(input logic keep, input logic [2:0] sew, input logic [2:0] lmul,
                           input logic [31:0] rs1);
    vec_instr_u  w;
    logic [31:0] vl;
    logic [31:0] vtype;
    logic [4:0]  rd;
    logic [31:0] data;
    w             = '0;
    w.cfg.cls     = CLS_CFG;
    w.cfg.rd      = 5'd7;
    w.cfg.keep_vl = keep;
    w.cfg.vsew    = sew;
    w.cfg.vlmul   = lmul;
    ref_cfg(w, rs1, exp_vl, exp_vtype, vl, vtype);
    issue_word(w, rs1, 1'b1);
    get_result(rd, data);
    check_value("cfg rd", 32'd7, rd);
    check_value("new vl", vl, data);
    exp_vl    = vl;
    exp_vtype = vtype;
    read_csr(CSR_SEL_VL, exp_vl);
    read_csr(CSR_SEL_VTYPE, exp_vtype);
  endtask

  task automatic send_op(input logic to_lsu, input logic exp_accept);
    vec_instr_u w;
    rng_main = lcg(rng_main);
    w        = '0;
    w.op.cls = to_lsu ? CLS_LSU : CLS_VFU;
    w.op.vd  = rng_main[30:26];
    w.op.vs1 = rng_main[25:21];
    // Accepted ops reach the units in issue order
    if (exp_accept) begin
      sent_instr.push_back(w);
      sent_rs1.push_back(rng_main);
    end
    issue_word(w, rng_main, exp_accept);
  endtask

  task automatic wait_dispatch(input int n);
    int cnt;
    cnt = 0;
    while (dispatched < n) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("vector request never reached its unit");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic complete_id(input int id);
    int idx;
    idx = -1;
    if (lsu_of_id[id]) begin
      lsu_done_valid_i = 1'b1;
      lsu_done_id_i    = ID_W'(id);
    end else begin
      vfu_done_valid_i = 1'b1;
      vfu_done_id_i    = ID_W'(id);
    end
    @(posedge clk_i);
    #1;
    vfu_done_valid_i = 1'b0;
    lsu_done_valid_i = 1'b0;
    foreach (pending[i]) begin
      if (pending[i] == id) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      pending.delete(idx);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("[%s] ok", test_name);
    end else begin
      tests_failed++;
      $display("[%s] %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  // Legal group size of step i together with SEW i % 3
  localparam logic [17:0] LMUL_SEQ = {LMUL_2, LMUL_4, LMUL_1, LMUL_8, LMUL_F2, LMUL_F4};

  initial begin : main_seq
    vec_instr_u  w;
    logic [31:0] vl;
    logic [31:0] vtype;
    logic [4:0]  rd;
    logic [31:0] data;
    int          ops;
    arst_n_i         = 1'b0;
    issue_valid_i    = 1'b0;
    issue_instr_i    = '0;
    issue_rs1_i      = '0;
    result_ready_i   = 1'b0;
    vfu_req_ready_i  = 1'b0;
    lsu_req_ready_i  = 1'b0;
    vfu_done_valid_i = 1'b0;
    vfu_done_id_i    = '0;
    lsu_done_valid_i = 1'b0;
    lsu_done_id_i    = '0;
    rng_main         = 32'd38;
    rng_ready        = 32'd38;
    busy_model       = '0;
    dispatched       = 0;
    exp_vl           = 32'd0;
    exp_vtype        = 32'h8000_0000;
    tests_run        = 0;
    tests_failed     = 0;
    ops              = 0;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    start_test("reset_state");
    check_value("issue ready", 32'd1, issue_ready_o);
    check_value("unit request", 32'd0, vfu_req_valid_o | lsu_req_valid_o);
    check_value("result valid", 32'd0, result_valid_o);
    read_csr(CSR_SEL_VL, 32'd0);
    read_csr(CSR_SEL_VTYPE, 32'h8000_0000);
    read_csr(CSR_SEL_VLENB, VLEN / 8);
    read_csr(2'd3, 32'd0);
    send_op(1'b0, 1'b0);
    w        = '0;
    w.op.cls = 3'd5;
    issue_word(w, 32'd0, 1'b0);
    idle(4);
    check_value("requests after rejects", 32'd0, dispatched);
    check_value("result after rejects", 32'd0, result_valid_o);
    finish_test();

    start_test("legal_config");
    for (int i = 0; i < 6; i++) begin
      rng_main = lcg(rng_main);
      configure(1'b0, 3'(i % 3), LMUL_SEQ[i*3 +: 3],
                (i % 3 == 0) ? 32'hffff_ffff : {26'd0, rng_main[31:26]});
    end
    finish_test();

    start_test("illegal_vtype");
    configure(1'b0, 3'd3, LMUL_1, 32'd10);
    configure(1'b0, SEW_8, 3'd4, 32'd10);
    configure(1'b0, SEW_16, LMUL_F4, 32'd10);
    finish_test();

    // Ratio 16/2 equals 32/4, then 8/4 breaks it
    start_test("keep_vl");
    configure(1'b0, SEW_16, LMUL_2, 32'd20);
    configure(1'b1, SEW_32, LMUL_4, 32'd5);
    configure(1'b1, SEW_8, LMUL_4, 32'd5);
    finish_test();

    start_test("vector_ops");
    configure(1'b0, SEW_32, LMUL_1, 32'hffff_ffff);
    for (int i = 0; i < 9; i++) begin
      rng_main = lcg(rng_main);
      send_op(rng_main[31], 1'b1);
      ops++;
      wait_dispatch(ops);
      if (pending.size() >= 2) begin
        complete_id(pending[0]);
      end
    end
    while (pending.size() > 0) begin
      complete_id(pending[0]);
    end
    // Fill every id, then one more must wait for a completion
    for (int i = 0; i < NR_INSN; i++) begin
      send_op(i[0], 1'b1);
      ops++;
      wait_dispatch(ops);
    end
    send_op(1'b0, 1'b1);
    ops++;
    idle(6);
    check_value("requests while full", ops - 1, dispatched);
    complete_id(2);
    wait_dispatch(ops);
    check_value("id after completion", 32'd2, pending[pending.size() - 1]);
    while (pending.size() > 0) begin
      complete_id(pending[0]);
    end
    check_value("dispatch count", ops, dispatched);
    finish_test();

    start_test("back_pressure");
    w           = '0;
    w.cfg.cls   = CLS_CFG;
    w.cfg.rd    = 5'd9;
    w.cfg.vsew  = SEW_8;
    w.cfg.vlmul = LMUL_2;
    ref_cfg(w, 32'd40, exp_vl, exp_vtype, vl, vtype);
    issue_word(w, 32'd40, 1'b1);
    w            = '0;
    w.op.cls     = CLS_CSR;
    w.op.rd      = 5'd10;
    w.op.csr_sel = CSR_SEL_VL;
    issue_word(w, 32'd0, 1'b1);
    repeat (5) begin
      check_value("issue ready while full", 32'd0, issue_ready_o);
      check_value("held result valid", 32'd1, result_valid_o);
      check_value("held result data", vl, result_data_o);
      idle(1);
    end
    get_result(rd, data);
    check_value("cfg rd", 32'd9, rd);
    check_value("cfg vl", vl, data);
    exp_vl    = vl;
    exp_vtype = vtype;
    get_result(rd, data);
    check_value("csr rd", 32'd10, rd);
    check_value("csr vl after commit", exp_vl, data);
    finish_test();

    $display("Tests run: %0d, failing: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verification
src/vec_ctrl_pkg.sv
src/vec_req_if.sv
src/vec_decoder.sv
src/vec_req_buffer.sv
src/vec_csr_file.sv
src/vec_insn_tracker.sv
src/vec_issuer.sv
src/vec_ctrl_top.sv
verification/vec_ctrl_tb.sv
